/* logic/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    // machine geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // branch offsets are word counts
    localparam int OFFS_SHIFT = 2;
    // bl writes its return address here
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd1;

    // major opcode, inst[31:26]
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;

    // inst[25:22]
    localparam logic [3:0] OP4_3R     = 4'h0;
    localparam logic [3:0] OP4_SHIFTI = 4'h1;
    localparam logic [3:0] OP4_LDW    = 4'h2;
    localparam logic [3:0] OP4_STW    = 4'h6;
    localparam logic [3:0] OP4_SLTI   = 4'h8;
    localparam logic [3:0] OP4_SLTUI  = 4'h9;
    localparam logic [3:0] OP4_ADDI   = 4'ha;
    localparam logic [3:0] OP4_ANDI   = 4'hd;
    localparam logic [3:0] OP4_ORI    = 4'he;
    localparam logic [3:0] OP4_XORI   = 4'hf;

    // inst[21:20]
    localparam logic [1:0] OP2_SHIFTI = 2'h0;
    localparam logic [1:0] OP2_3R     = 2'h1;

    // inst[19:15], 3R group then shift-immediate group
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLL  = 5'h0e;
    localparam logic [4:0] OP5_SRL  = 5'h0f;
    localparam logic [4:0] OP5_SRA  = 5'h10;
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_SRAI = 5'h11;

    // overlapping views of one instruction word
    typedef struct packed {
        logic [5:0]            op_31_26;
        logic [3:0]            op_25_22;
        logic [1:0]            op_21_20;
        logic [4:0]            op_19_15;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [11:0]           i12;
        logic [15:0]           i16;
        logic [19:0]           i20;
        logic [25:0]           i26;
    } inst_fields_t;

    // one-hot, add sits at bit 0
    typedef struct packed {
        logic op_lui;
        logic op_sra;
        logic op_srl;
        logic op_sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic op_sltu;
        logic op_slt;
        logic op_sub;
        logic op_add;
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JIRL,
        BR_B,
        BR_BL
    } br_kind_e;

    typedef struct packed {
        alu_op_t               alu_op;
        br_kind_e              br_kind;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  res_from_mem;
        logic                  gr_we;
        logic                  mem_we;
        logic                  src_reg_is_rd;
        logic                  reads_rj;
        logic                  reads_r2;
        logic [REG_ADDR_W-1:0] dest;
    } decoded_t;

    // pc lands in the low word, as on the old flat bus
    typedef struct packed {
        logic                  res_from_mem;
        logic                  src2_is_imm;
        logic                  src1_is_pc;
        alu_op_t               alu_op;
        logic                  mem_we;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       rkd_value;
        logic [XLEN-1:0]       rj_value;
        logic [XLEN-1:0]       pc;
    } ds_to_es_t;

    typedef struct packed {
        logic            br_taken;
        logic [XLEN-1:0] br_target;
    } br_bus_t;

    function automatic inst_fields_t split_fields(input logic [XLEN-1:0] inst);
        inst_fields_t f;
        f.op_31_26 = inst[31:26];
        f.op_25_22 = inst[25:22];
        f.op_21_20 = inst[21:20];
        f.op_19_15 = inst[19:15];
        f.rd       = inst[4:0];
        f.rj       = inst[9:5];
        f.rk       = inst[14:10];
        f.i12      = inst[21:10];
        f.i16      = inst[25:10];
        f.i20      = inst[24:5];
        // offs26 is split, high half sits in the low bits
        f.i26      = {inst[9:0], inst[25:10]};
        return f;
    endfunction

endpackage

`default_nettype wire

/* logic/producer_if.sv */
`timescale 1ns/1ps
`default_nettype none

// write-back tap of one later stage, seen by decode
interface producer_if import decode_pkg::*; ();
    // stage will write a register
    logic                  we;
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       data;
    // data not ready yet, load still in flight
    logic                  is_load;

    modport source (
        output we,
        output dest,
        output data,
        output is_load
    );

    modport sink (
        input we,
        input dest,
        input data,
        input is_load
    );
endinterface

`default_nettype wire

/* logic/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output decoded_t        dec,
    output logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] br_offs
);
    inst_fields_t f;

    // opcode groups
    logic grp_3r;
    logic grp_shi;
    logic grp_alui;

    logic inst_add, inst_sub, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_slli, inst_srli, inst_srai;
    logic inst_addi, inst_slti, inst_sltui;
    logic inst_andi, inst_ori, inst_xori;
    logic inst_lu12i, inst_pcaddu12i;
    logic inst_ld, inst_st;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;

    // immediate selection
    logic need_ui5;
    logic need_si12;
    logic need_ui12;
    logic need_si20;
    logic need_si26;
    logic src2_is_4;

    assign f = split_fields(inst);

    assign grp_3r   = f.op_31_26 == OP6_ALU && f.op_25_22 == OP4_3R && f.op_21_20 == OP2_3R;
    assign grp_shi  = f.op_31_26 == OP6_ALU && f.op_25_22 == OP4_SHIFTI
                      && f.op_21_20 == OP2_SHIFTI;
    assign grp_alui = f.op_31_26 == OP6_ALU;

    assign inst_add  = grp_3r && f.op_19_15 == OP5_ADD;
    assign inst_sub  = grp_3r && f.op_19_15 == OP5_SUB;
    assign inst_slt  = grp_3r && f.op_19_15 == OP5_SLT;
    assign inst_sltu = grp_3r && f.op_19_15 == OP5_SLTU;
    assign inst_nor  = grp_3r && f.op_19_15 == OP5_NOR;
    assign inst_and  = grp_3r && f.op_19_15 == OP5_AND;
    assign inst_or   = grp_3r && f.op_19_15 == OP5_OR;
    assign inst_xor  = grp_3r && f.op_19_15 == OP5_XOR;
    assign inst_sll  = grp_3r && f.op_19_15 == OP5_SLL;
    assign inst_srl  = grp_3r && f.op_19_15 == OP5_SRL;
    assign inst_sra  = grp_3r && f.op_19_15 == OP5_SRA;
    assign inst_slli = grp_shi && f.op_19_15 == OP5_SLLI;
    assign inst_srli = grp_shi && f.op_19_15 == OP5_SRLI;
    assign inst_srai = grp_shi && f.op_19_15 == OP5_SRAI;

    // 12-bit immediate forms only look at op_25_22
    assign inst_addi  = grp_alui && f.op_25_22 == OP4_ADDI;
    assign inst_slti  = grp_alui && f.op_25_22 == OP4_SLTI;
    assign inst_sltui = grp_alui && f.op_25_22 == OP4_SLTUI;
    assign inst_andi  = grp_alui && f.op_25_22 == OP4_ANDI;
    assign inst_ori   = grp_alui && f.op_25_22 == OP4_ORI;
    assign inst_xori  = grp_alui && f.op_25_22 == OP4_XORI;
    assign inst_ld    = f.op_31_26 == OP6_MEM && f.op_25_22 == OP4_LDW;
    assign inst_st    = f.op_31_26 == OP6_MEM && f.op_25_22 == OP4_STW;

    // inst[25] must be clear for the si20 forms
    assign inst_lu12i     = f.op_31_26 == OP6_LU12I && !f.op_25_22[3];
    assign inst_pcaddu12i = f.op_31_26 == OP6_PCADDU12I && !f.op_25_22[3];

    assign inst_jirl = f.op_31_26 == OP6_JIRL;
    assign inst_b    = f.op_31_26 == OP6_B;
    assign inst_bl   = f.op_31_26 == OP6_BL;
    assign inst_beq  = f.op_31_26 == OP6_BEQ;
    assign inst_bne  = f.op_31_26 == OP6_BNE;

    assign need_ui5  = inst_slli | inst_srli | inst_srai;
    assign need_si12 = inst_addi | inst_ld | inst_st | inst_slti | inst_sltui;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i | inst_pcaddu12i;
    assign need_si26 = inst_b | inst_bl;
    // link value is pc + 4
    assign src2_is_4 = inst_jirl | inst_bl;

    always_comb
    begin
        dec = '0;
        dec.alu_op.op_add  = inst_add | inst_addi | inst_ld | inst_st
                             | inst_jirl | inst_bl | inst_pcaddu12i;
        dec.alu_op.op_sub  = inst_sub;
        dec.alu_op.op_slt  = inst_slt | inst_slti;
        dec.alu_op.op_sltu = inst_sltu | inst_sltui;
        dec.alu_op.op_and  = inst_and | inst_andi;
        dec.alu_op.op_nor  = inst_nor;
        dec.alu_op.op_or   = inst_or | inst_ori;
        dec.alu_op.op_xor  = inst_xor | inst_xori;
        dec.alu_op.op_sll  = inst_sll | inst_slli;
        dec.alu_op.op_srl  = inst_srl | inst_srli;
        dec.alu_op.op_sra  = inst_sra | inst_srai;
        dec.alu_op.op_lui  = inst_lu12i;

        dec.br_kind = inst_beq  ? BR_BEQ  :
                      inst_bne  ? BR_BNE  :
                      inst_jirl ? BR_JIRL :
                      inst_b    ? BR_B    :
                      inst_bl   ? BR_BL   : BR_NONE;

        dec.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
        dec.src2_is_imm  = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;
        dec.res_from_mem = inst_ld;
        // unknown encodings still write, as the old stage did
        dec.gr_we        = ~inst_st & ~inst_beq & ~inst_bne & ~inst_b;
        dec.mem_we       = inst_st;
        // st.w and the compare branches read rd on port 2
        dec.src_reg_is_rd = inst_st | inst_beq | inst_bne;
        dec.reads_rj = grp_3r | need_ui5 | need_si12 | need_ui12 | inst_jirl
                       | inst_beq | inst_bne;
        dec.reads_r2 = grp_3r | inst_st | inst_beq | inst_bne;
        dec.dest     = inst_bl ? LINK_REG : f.rd;
    end

    assign imm = src2_is_4 ? 32'd4                  :
                 need_si20 ? {f.i20, 12'b0}         :
                 need_ui5  ? {27'b0, f.rk}          :
                 need_si12 ? XLEN'($signed(f.i12))  :
                 need_ui12 ? {20'b0, f.i12}         : '0;

    // word offset, sign extended then scaled
    assign br_offs = need_si26 ? XLEN'($signed(f.i26)) << OFFS_SHIFT
                               : XLEN'($signed(f.i16)) << OFFS_SHIFT;
endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile import decode_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    producer_if.sink              wr
);
    logic [XLEN-1:0] regs [NUM_REGS];

    // writeback port, r0 never stored
    always_ff @(posedge clk)
    begin
        if (wr.we && wr.dest != '0)
        begin
            regs[wr.dest] <= wr.data;
        end
    end

    // same-cycle write is picked up by the ws forward, not here
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

`default_nettype wire

/* logic/bypass_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module bypass_unit import decode_pkg::*; (
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    input  logic                  reads_rj,
    input  logic                  reads_r2,
    input  logic [XLEN-1:0]       rf_rdata1,
    input  logic [XLEN-1:0]       rf_rdata2,
    producer_if.sink              es,
    producer_if.sink              ms,
    producer_if.sink              ws,
    output logic [XLEN-1:0]       rj_value,
    output logic [XLEN-1:0]       rkd_value,
    output logic                  load_block
);
    // per-stage, per-port matches
    logic es_hit1;
    logic es_hit2;
    logic ms_hit1;
    logic ms_hit2;
    logic ws_hit1;
    logic ws_hit2;

    // stage writes a live register that this port actually reads
    function automatic logic hit(
        input logic                  we,
        input logic [REG_ADDR_W-1:0] dest,
        input logic [REG_ADDR_W-1:0] addr,
        input logic                  reads
    );
        return we && dest != '0 && dest == addr && reads;
    endfunction

    assign es_hit1 = hit(es.we, es.dest, raddr1, reads_rj);
    assign es_hit2 = hit(es.we, es.dest, raddr2, reads_r2);
    assign ms_hit1 = hit(ms.we, ms.dest, raddr1, reads_rj);
    assign ms_hit2 = hit(ms.we, ms.dest, raddr2, reads_r2);
    assign ws_hit1 = hit(ws.we, ws.dest, raddr1, reads_rj);
    assign ws_hit2 = hit(ws.we, ws.dest, raddr2, reads_r2);

    // youngest producer wins
    assign rj_value  = es_hit1 ? es.data :
                       ms_hit1 ? ms.data :
                       ws_hit1 ? ws.data : rf_rdata1;
    assign rkd_value = es_hit2 ? es.data :
                       ms_hit2 ? ms.data :
                       ws_hit2 ? ws.data : rf_rdata2;

    // load in execute has no data yet, must wait a cycle or more
    assign load_block = (es_hit1 || es_hit2) && es.is_load;
endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import decode_pkg::*; (
    input  br_kind_e        br_kind,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    input  logic [XLEN-1:0] br_offs,
    output logic            taken,
    output logic [XLEN-1:0] target
);
    logic rj_eq_rd;

    // beq/bne compare rj against rd, which arrives on port 2
    assign rj_eq_rd = rj_value == rkd_value;

    always_comb
    begin
        case (br_kind)
            BR_BEQ:  taken = rj_eq_rd;
            BR_BNE:  taken = !rj_eq_rd;
            BR_JIRL: taken = 1'b1;
            BR_B:    taken = 1'b1;
            BR_BL:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = (br_kind == BR_JIRL) ? rj_value + br_offs : pc + br_offs;
endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // fetch side
    input  logic                  fs_to_ds_valid,
    input  logic [XLEN-1:0]       fs_to_ds_inst,
    input  logic [XLEN-1:0]       fs_to_ds_pc,
    output logic                  ds_allow_in,
    // execute side
    output logic                  ds_to_es_valid,
    output ds_to_es_t             ds_to_es,
    input  logic                  es_allow_in,
    // redirect to fetch
    output logic                  br_taken,
    output logic [XLEN-1:0]       br_target,
    // stage taps
    input  logic                  es_we,
    input  logic [REG_ADDR_W-1:0] es_dest,
    input  logic                  es_is_load,
    input  logic [XLEN-1:0]       es_data,
    input  logic                  ms_we,
    input  logic [REG_ADDR_W-1:0] ms_dest,
    input  logic [XLEN-1:0]       ms_data,
    input  logic                  ws_we,
    input  logic [REG_ADDR_W-1:0] ws_dest,
    input  logic [XLEN-1:0]       ws_data
);
    logic            ds_valid;
    logic [XLEN-1:0] ds_inst;
    logic [XLEN-1:0] ds_pc;

    inst_fields_t    f;
    decoded_t        dec;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] br_offs;

    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [XLEN-1:0]       rj_value;
    logic [XLEN-1:0]       rkd_value;

    logic            load_block;
    logic            ready_go;
    // handover to execute this cycle
    logic            to_es_go;
    logic            bu_taken;
    logic [XLEN-1:0] bu_target;
    br_bus_t         br_bus;

    producer_if es_tap ();
    producer_if ms_tap ();
    producer_if ws_tap ();

    // taps from the flat ports
    assign es_tap.we      = es_we;
    assign es_tap.dest    = es_dest;
    assign es_tap.data    = es_data;
    assign es_tap.is_load = es_is_load;
    assign ms_tap.we      = ms_we;
    assign ms_tap.dest    = ms_dest;
    assign ms_tap.data    = ms_data;
    assign ms_tap.is_load = 1'b0;
    // writeback data is always final
    assign ws_tap.we      = ws_we;
    assign ws_tap.dest    = ws_dest;
    assign ws_tap.data    = ws_data;
    assign ws_tap.is_load = 1'b0;

    // input register, zero out of reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ds_inst <= '0;
            ds_pc   <= '0;
        end
        else if (fs_to_ds_valid && ds_allow_in)
        begin
            ds_inst <= fs_to_ds_inst;
            ds_pc   <= fs_to_ds_pc;
        end
    end

    // valid/allow_in levels
    assign ready_go       = !load_block;
    assign ds_allow_in    = !ds_valid || (ready_go && es_allow_in);
    assign ds_to_es_valid = ds_valid && ready_go;
    assign to_es_go       = ds_to_es_valid && es_allow_in;

    // a taken branch kills whatever fetch offers in its handover cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ds_valid <= 1'b0;
        end
        else if (br_bus.br_taken)
        begin
            ds_valid <= 1'b0;
        end
        else if (ds_allow_in)
        begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    assign f         = split_fields(ds_inst);
    assign rf_raddr1 = f.rj;
    assign rf_raddr2 = dec.src_reg_is_rd ? f.rd : f.rk;

    inst_decoder inst_decoder_i (
        .inst    (ds_inst),
        .dec     (dec),
        .imm     (imm),
        .br_offs (br_offs)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_tap)
    );

    bypass_unit bypass_unit_i (
        .raddr1     (rf_raddr1),
        .raddr2     (rf_raddr2),
        .reads_rj   (dec.reads_rj),
        .reads_r2   (dec.reads_r2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .es         (es_tap),
        .ms         (ms_tap),
        .ws         (ws_tap),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .load_block (load_block)
    );

    branch_unit branch_unit_i (
        .br_kind   (dec.br_kind),
        .pc        (ds_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .taken     (bu_taken),
        .target    (bu_target)
    );

    // redirect only when the branch actually hands over
    assign br_bus.br_taken  = bu_taken && to_es_go;
    assign br_bus.br_target = br_bus.br_taken ? bu_target : '0;
    assign br_taken         = br_bus.br_taken;
    assign br_target        = br_bus.br_target;

    always_comb
    begin
        ds_to_es.pc           = ds_pc;
        ds_to_es.rj_value     = rj_value;
        ds_to_es.rkd_value    = rkd_value;
        ds_to_es.imm          = imm;
        ds_to_es.dest         = dec.dest;
        ds_to_es.gr_we        = dec.gr_we;
        ds_to_es.mem_we       = dec.mem_we;
        ds_to_es.alu_op       = dec.alu_op;
        ds_to_es.src1_is_pc   = dec.src1_is_pc;
        ds_to_es.src2_is_imm  = dec.src2_is_imm;
        ds_to_es.res_from_mem = dec.res_from_mem;
    end
endmodule

`default_nettype wire

/* sim/decode_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assertions import decode_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      load_block,
    input logic      ds_valid,
    input logic      ds_to_es_valid,
    input logic      es_allow_in,
    input logic      br_taken,
    input ds_to_es_t ds_to_es
);
    // load-use hazard keeps the instruction in place
    load_stall_holds: assert property (
        @(posedge clk) disable iff (reset)
        (ds_valid && load_block) |=> ds_valid && $stable(ds_to_es.pc)
    )
    else $error("instruction left decode during a load-use stall");

    // fetch offer in the handover cycle of a taken branch is dropped
    taken_drops_next: assert property (
        @(posedge clk) disable iff (reset) br_taken |=> !ds_to_es_valid
    )
    else $error("ds_to_es_valid high right after a taken branch");

    // held payload under back-pressure
    payload_held: assert property (
        @(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allow_in) |=> $stable(ds_to_es)
    )
    else $error("ds_to_es changed while stalled by execute");
endmodule

`default_nettype wire

/* sim/tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();
    localparam int NCOL           = 26;
    localparam int ACCEPT_TIMEOUT = 8;

    logic                  clk;
    logic                  reset;
    logic                  fs_to_ds_valid;
    logic [XLEN-1:0]       fs_to_ds_inst;
    logic [XLEN-1:0]       fs_to_ds_pc;
    logic                  ds_allow_in;
    logic                  ds_to_es_valid;
    ds_to_es_t             ds_to_es;
    logic                  es_allow_in;
    logic                  br_taken;
    logic [XLEN-1:0]       br_target;
    logic                  es_we;
    logic [REG_ADDR_W-1:0] es_dest;
    logic                  es_is_load;
    logic [XLEN-1:0]       es_data;
    logic                  ms_we;
    logic [REG_ADDR_W-1:0] ms_dest;
    logic [XLEN-1:0]       ms_data;
    logic                  ws_we;
    logic [REG_ADDR_W-1:0] ws_dest;
    logic [XLEN-1:0]       ws_data;

    // one stimulus line, column order as in the data file
    logic [31:0] col [NCOL];
    // pc of the payload last taken from fetch
    logic [31:0] held_pc;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    decode_stage decode_stage_i (.*);

    bind decode_stage decode_stage_assertions decode_stage_assertions_i (
        .clk            (clk),
        .reset          (reset),
        .load_block     (load_block),
        .ds_valid       (ds_valid),
        .ds_to_es_valid (ds_to_es_valid),
        .es_allow_in    (es_allow_in),
        .br_taken       (br_taken),
        .ds_to_es       (ds_to_es)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0d ns: test %0h %s is %h, expected %h",
                     $time, col[0], name, got, exp);
            errors++;
        end
    endtask

    // fetch handshake, sampled away from the edge
    task automatic wait_accept(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < ACCEPT_TIMEOUT)
        begin
            @(negedge clk);
            ok = fs_to_ds_valid && ds_allow_in;
            @(posedge clk);
            n++;
        end
    endtask

    task automatic run_vector();
        bit ok;
        int err_before;
        err_before = errors;
        @(posedge clk);
        // preload through the writeback tap, lands in the regfile next edge
        if (col[1] == 32'd1)
        begin
            ws_we   <= 1'b1;
            ws_dest <= col[2][4:0];
            ws_data <= col[3];
            @(posedge clk);
        end
        ws_we          <= 1'b0;
        fs_to_ds_valid <= col[5][0];
        fs_to_ds_inst  <= col[6];
        fs_to_ds_pc    <= col[7];
        es_we          <= col[8][0];
        es_dest        <= col[9][4:0];
        es_is_load     <= col[10][0];
        es_data        <= col[11];
        ms_we          <= col[12][0];
        ms_dest        <= col[13][4:0];
        ms_data        <= col[14];
        es_allow_in    <= col[15][0];
        // mode 0 checks the cycle after acceptance, mode 1 this cycle
        if (col[4] == 32'd0)
        begin
            wait_accept(ok);
            if (!ok)
            begin
                $display("test %0h: fetch payload was not accepted within %0d cycles",
                         col[0], ACCEPT_TIMEOUT);
                errors++;
            end
            else
            begin
                held_pc = col[7];
            end
            fs_to_ds_valid <= 1'b0;
            // live ws tap, seen only through the forward
            if (col[1] == 32'd2)
            begin
                ws_we   <= 1'b1;
                ws_dest <= col[2][4:0];
                ws_data <= col[3];
            end
        end
        @(negedge clk);
        check_value("ds_to_es_valid", 32'(ds_to_es_valid), col[16]);
        check_value("ds_allow_in", 32'(ds_allow_in), col[17]);
        check_value("br_taken", 32'(br_taken), col[18]);
        check_value("br_target", br_target, col[19]);
        if (col[16][0])
        begin
            // payload stays put until it hands over
            check_value("pc", ds_to_es.pc, held_pc);
            check_value("rj_value", ds_to_es.rj_value, col[20]);
            check_value("rkd_value", ds_to_es.rkd_value, col[21]);
            check_value("imm", ds_to_es.imm, col[22]);
            check_value("dest", 32'(ds_to_es.dest), col[23]);
            check_value("alu_op", 32'(ds_to_es.alu_op), col[24]);
            check_value("gr_we", 32'(ds_to_es.gr_we), 32'(col[25][4]));
            check_value("mem_we", 32'(ds_to_es.mem_we), 32'(col[25][3]));
            check_value("src1_is_pc", 32'(ds_to_es.src1_is_pc), 32'(col[25][2]));
            check_value("src2_is_imm", 32'(ds_to_es.src2_is_imm), 32'(col[25][1]));
            check_value("res_from_mem", 32'(ds_to_es.res_from_mem), 32'(col[25][0]));
        end
        if (errors == err_before)
        begin
            tests_passed++;
            $display("test %0h passed", col[0]);
        end
        else
        begin
            tests_failed++;
            $display("test %0h failed", col[0]);
        end
    endtask

    initial
    begin
        string line;
        int    fd;
        int    n;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        held_pc        = '0;
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_inst  = '0;
        fs_to_ds_pc    = '0;
        es_allow_in    = 1'b1;
        es_we          = 1'b0;
        es_dest        = '0;
        es_is_load     = 1'b0;
        es_data        = '0;
        ms_we          = 1'b0;
        ms_dest        = '0;
        ms_data        = '0;
        ws_we          = 1'b0;
        ws_dest        = '0;
        ws_data        = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("sim/decode_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file sim/decode_stim.txt");
            $display("SIMULATION FAILED");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                // comment and blank lines
                if (line.len() < 4 || line.getc(0) == "#")
                begin
                    continue;
                end
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                    col[16], col[17], col[18], col[19], col[20], col[21], col[22],
                    col[23], col[24], col[25]);
                if (n != NCOL)
                begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                end
                else
                begin
                    run_vector();
                end
            end
            $fclose(fd);
            // one more edge so the bound checks see the last handover
            @(negedge clk);
            $display("tests passed %0d, tests failed %0d, check errors %0d",
                     tests_passed, tests_failed, errors);
            if (errors == 0 && tests_passed > 0)
            begin
                $display("SIMULATION PASSED");
            end
            else
            begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end
endmodule

`default_nettype wire

/* compile.f */
logic/decode_pkg.sv
logic/producer_if.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/bypass_unit.sv
logic/branch_unit.sv
logic/decode_stage.sv
sim/decode_stage_assertions.sv
sim/tb_decode_stage.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_decode_stage
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "SIMULATION PASSED" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* sim/decode_stim.txt */
# test pre wdst wdata mode fsv inst pc esw esd esl esdata msw msd msdata eai
#   vld ain brt brtgt rj rkd imm dst alu ctl(gr_we mem_we src1_pc src2_imm res_mem)
01 1 04 64   1 0 00000000 000 0 00 0 0    0 00 0    1 0 1 0 000 0    0    0        00 000 00
02 1 05 c8   1 0 00000000 000 0 00 0 0    0 00 0    1 0 1 0 000 0    0    0        00 000 00
03 1 06 64   1 0 00000000 000 0 00 0 0    0 00 0    1 0 1 0 000 0    0    0        00 000 00
04 1 07 1000 1 0 00000000 000 0 00 0 0    0 00 0    1 0 1 0 000 0    0    0        00 000 00
05 0 00 0    0 1 00101483 100 0 00 0 0    0 00 0    1 1 1 0 000 64   c8   0        03 001 10
06 0 00 0    0 1 001110a9 104 0 00 0 0    0 00 0    1 1 1 0 000 c8   64   0        09 002 10
07 0 00 0    0 1 0012948a 108 0 00 0 0    0 00 0    1 1 1 0 000 64   c8   0        0a 008 10
08 0 00 0    0 1 0014148b 10c 0 00 0 0    0 00 0    1 1 1 0 000 64   c8   0        0b 020 10
09 0 00 0    0 1 001810ac 110 0 00 0 0    0 00 0    1 1 1 0 000 c8   64   0        0c 400 10
10 0 00 0    0 1 0040908d 114 0 00 0 0    0 00 0    1 1 1 0 000 64   64   4        0d 100 12
11 0 00 0    0 1 02bf90ae 118 0 00 0 0    0 00 0    1 1 1 0 000 c8   64   ffffffe4 0e 001 12
12 0 00 0    0 1 0360148f 11c 0 00 0 0    0 00 0    1 1 1 0 000 64   c8   805      0f 010 12
13 0 00 0    0 1 142410b0 120 0 00 0 0    0 00 0    1 1 1 0 000 c8   64   12085000 10 800 12
14 0 00 0    0 1 1c0010b1 200 0 00 0 0    0 00 0    1 1 1 0 000 c8   64   85000    11 001 16
15 0 00 0    0 1 00101483 300 1 04 0 aaaa 1 04 bbbb 1 1 1 0 000 aaaa c8   0        03 001 10
16 0 00 0    0 1 00101483 304 1 00 0 dead 1 04 bbbb 1 1 1 0 000 bbbb c8   0        03 001 10
17 2 08 cccc 0 1 00102083 308 0 00 0 0    0 00 0    1 1 1 0 000 64   cccc 0        03 001 10
18 0 00 0    0 1 00101483 30c 1 04 1 1234 0 00 0    1 0 0 0 000 0    0    0        00 000 00
19 0 00 0    1 0 00101483 30c 1 04 0 1234 0 00 0    1 1 1 0 000 1234 c8   0        03 001 10
20 0 00 0    0 1 58001086 400 0 00 0 0    0 00 0    1 1 1 1 410 64   64   0        06 000 00
21 0 00 0    0 1 58001085 500 0 00 0 0    0 00 0    1 1 1 0 000 64   c8   0        05 000 00
22 0 00 0    0 1 5c001085 600 0 00 0 0    0 00 0    1 1 1 1 610 64   c8   0        05 000 00
23 0 00 0    0 1 50021400 700 0 00 0 0    0 00 0    1 1 1 1 914 0    c8   0        00 000 00
24 0 00 0    0 1 54021400 800 0 00 0 0    0 00 0    1 1 1 1 a14 0    c8   4        01 001 16
25 0 00 0    0 1 4fff90e1 900 0 00 0 0    0 00 0    1 1 1 1 f90 1000 64   4        01 001 16
26 0 00 0    0 1 29802085 a00 0 00 0 0    0 00 0    1 1 1 0 000 64   c8   8        05 001 0a
27 0 00 0    0 1 28801092 a04 0 00 0 0    0 00 0    1 1 1 0 000 64   64   4        12 001 13
28 0 00 0    0 1 58001086 b00 0 00 0 0    0 00 0    0 1 0 0 000 64   64   0        06 000 00
29 0 00 0    1 1 00101483 b04 0 00 0 0    0 00 0    1 1 1 1 b10 64   64   0        06 000 00
30 0 00 0    1 0 00000000 b08 0 00 0 0    0 00 0    1 0 1 0 000 0    0    0        00 000 00
